//--- hdl/stepper_pkg.sv
package stepper_pkg;

  // Electrical phase, 256 microsteps per cycle
  // Bits 7:6 select the quadrant
  typedef logic [7:0] phase_t;

  // Off timer and fast decay threshold, in clock cycles
  typedef logic [9:0] long_time_t;

  // Blank timer and minimum on timer, in clock cycles
  typedef logic [7:0] short_time_t;

  // Coil current reference magnitude, full scale 255
  typedef logic [7:0] vref_t;

  // Chopper states, idle while the driver is disabled
  typedef enum logic [1:0] {
    chop_idle = 2'd0,
    chop_on   = 2'd1,
    chop_off  = 2'd2
  } chop_state_t;

endpackage

//--- hdl/coil_timer_if.sv
interface coil_timer_if;

  // Down-counters, zero means the window is not running
  stepper_pkg::short_time_t blank_timer;
  stepper_pkg::long_time_t  off_timer;
  stepper_pkg::short_time_t minimum_on_timer;

  // Single cycle request to start the off time
  logic offtimer_en;

  modport timer (
    output blank_timer,
    output off_timer,
    output minimum_on_timer,
    input  offtimer_en
  );

  modport control (
    input  blank_timer,
    input  off_timer,
    input  minimum_on_timer,
    output offtimer_en
  );

endinterface

//--- hdl/phase_decoder.sv
module phase_decoder (
  input  logic                clk,
  input  logic                resetn,
  input  stepper_pkg::phase_t phase_ct,
  output logic                s1,
  output logic                s2,
  output logic                s3,
  output logic                s4,
  output stepper_pkg::vref_t  vref_a,
  output stepper_pkg::vref_t  vref_b
);

  // Quarter wave table with entry i equal to round(255 * sin(i * pi / 128))
  localparam stepper_pkg::vref_t sine_table [0:64] = '{
      8'd0,   8'd6,   8'd13,  8'd19,  8'd25,  8'd31,  8'd37,  8'd44,
      8'd50,  8'd56,  8'd62,  8'd68,  8'd74,  8'd80,  8'd86,  8'd92,
      8'd98,  8'd103, 8'd109, 8'd115, 8'd120, 8'd126, 8'd131, 8'd136,
      8'd142, 8'd147, 8'd152, 8'd157, 8'd162, 8'd167, 8'd171, 8'd176,
      8'd180, 8'd185, 8'd189, 8'd193, 8'd197, 8'd201, 8'd205, 8'd208,
      8'd212, 8'd215, 8'd219, 8'd222, 8'd225, 8'd228, 8'd231, 8'd233,
      8'd236, 8'd238, 8'd240, 8'd242, 8'd244, 8'd246, 8'd247, 8'd249,
      8'd250, 8'd251, 8'd252, 8'd253, 8'd254, 8'd254, 8'd255, 8'd255,
      8'd255
  };

  logic       odd_quadrant;
  logic [5:0] fold;
  logic [6:0] sin_idx;
  logic [6:0] cos_idx;
  logic       cos_pos;
  logic       sin_pos;

  assign odd_quadrant = phase_ct[6];
  assign fold         = phase_ct[5:0];

  // Odd quadrants run the table backwards for sine, even ones for cosine
  assign sin_idx = odd_quadrant ? 7'd64 - {1'b0, fold} : {1'b0, fold};
  assign cos_idx = odd_quadrant ? {1'b0, fold} : 7'd64 - {1'b0, fold};

  // Zero crossings of cosine at 64 and 192 and of sine at 128 count as positive
  assign cos_pos = (phase_ct <= 8'd64) || (phase_ct >= 8'd192);
  assign sin_pos = (phase_ct <= 8'd128);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      // Decode of phase 0
      s1     <= 1'b1;
      s2     <= 1'b0;
      s3     <= 1'b1;
      s4     <= 1'b0;
      vref_a <= 8'd255;
      vref_b <= 8'd0;
    end else begin
      s1     <= cos_pos;
      s2     <= !cos_pos;
      s3     <= sin_pos;
      s4     <= !sin_pos;
      vref_a <= sine_table[cos_idx];
      vref_b <= sine_table[sin_idx];
    end
  end

endmodule

//--- hdl/chopper_timers.sv
module chopper_timers (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     enable,
  input  stepper_pkg::long_time_t  config_off_time,
  input  stepper_pkg::short_time_t config_blank_time,
  input  stepper_pkg::short_time_t config_min_on_time,
  coil_timer_if.timer              timers
);

  stepper_pkg::chop_state_t state;
  stepper_pkg::short_time_t blank_ct;
  stepper_pkg::long_time_t  off_ct;
  stepper_pkg::short_time_t min_on_ct;

  always_ff @(posedge clk) begin
    if (!resetn || !enable) begin
      state     <= stepper_pkg::chop_idle;
      blank_ct  <= '0;
      off_ct    <= '0;
      min_on_ct <= '0;
    end else begin
      case (state)
        stepper_pkg::chop_idle: begin
          // Enabling starts an on time with fresh blanking
          state     <= stepper_pkg::chop_on;
          blank_ct  <= config_blank_time;
          min_on_ct <= config_min_on_time;
          off_ct    <= '0;
        end

        stepper_pkg::chop_on: begin
          if (blank_ct != '0) begin
            blank_ct <= blank_ct - 1'b1;
          end
          if (min_on_ct != '0) begin
            min_on_ct <= min_on_ct - 1'b1;
          end
          // Peak current reached, start the fixed off time
          if (timers.offtimer_en) begin
            state  <= stepper_pkg::chop_off;
            off_ct <= config_off_time;
          end
        end

        stepper_pkg::chop_off: begin
          // Min-on keeps running so a short on time stays visible as a fault
          if (min_on_ct != '0) begin
            min_on_ct <= min_on_ct - 1'b1;
          end
          if (off_ct <= 10'd1) begin
            // Off time over, blanking starts on the same edge
            state     <= stepper_pkg::chop_on;
            off_ct    <= '0;
            blank_ct  <= config_blank_time;
            min_on_ct <= config_min_on_time;
          end else begin
            off_ct <= off_ct - 1'b1;
          end
        end

        default: begin
          state <= stepper_pkg::chop_idle;
        end
      endcase
    end
  end

  assign timers.blank_timer      = blank_ct;
  assign timers.off_timer        = off_ct;
  assign timers.minimum_on_timer = min_on_ct;

endmodule

//--- hdl/microstepper_control.sv
module microstepper_control (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    step,
  input  logic                    dir,
  input  logic                    enable_in,
  input  logic                    config_invert_highside,
  input  logic                    config_invert_lowside,
  input  stepper_pkg::long_time_t config_fastdecay_threshold,
  input  logic                    s1,
  input  logic                    s2,
  input  logic                    s3,
  input  logic                    s4,
  coil_timer_if.control           coil_a,
  coil_timer_if.control           coil_b,
  input  logic                    analog_cmp1,
  input  logic                    analog_cmp2,
  output stepper_pkg::phase_t     phase_ct,
  output logic                    enable,
  output logic                    faultn,
  output logic                    phase_a1_h_out,
  output logic                    phase_a2_h_out,
  output logic                    phase_b1_h_out,
  output logic                    phase_b2_h_out,
  output logic                    phase_a1_l_out,
  output logic                    phase_a2_l_out,
  output logic                    phase_b1_l_out,
  output logic                    phase_b2_l_out
);

  // Two sync stages, then one stage for edge detect
  logic [3:0] step_r;
  logic [2:0] dir_r;
  logic       step_rising;
  logic       fast_a, fast_b, slow_a, slow_b;
  logic       a1_h, a2_h, b1_h, b2_h;
  logic       a1_l, a2_l, b1_l, b2_l;
  logic       drive_ok;

  always_ff @(posedge clk) begin
    step_r <= {step_r[2:0], step};
    dir_r  <= {dir_r[1:0], dir};
  end

  assign step_rising = step_r[2] && !step_r[3];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase_ct <= '0;
    end else if (step_rising) begin
      phase_ct <= dir_r[2] ? phase_ct + 1'b1 : phase_ct - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      enable <= 1'b0;
    end else begin
      enable <= enable_in;
    end
  end

  // Off time started while min-on still running, latched until reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      faultn <= 1'b1;
    end else if (enable &&
                 ((coil_a.off_timer != '0 && coil_a.minimum_on_timer != '0) ||
                  (coil_b.off_timer != '0 && coil_b.minimum_on_timer != '0))) begin
      faultn <= 1'b0;
    end
  end

  // Fast decay for the first part of the off time, slow decay for the rest
  assign fast_a = (coil_a.off_timer != '0) && (coil_a.off_timer >= config_fastdecay_threshold);
  assign fast_b = (coil_b.off_timer != '0) && (coil_b.off_timer >= config_fastdecay_threshold);
  assign slow_a = (coil_a.off_timer != '0) && !fast_a;
  assign slow_b = (coil_b.off_timer != '0) && !fast_b;

  // Fast decay drives the opposite diagonal of the bridge
  assign a1_h = !slow_a && (fast_a ? !s1 : s1);
  assign a2_h = !slow_a && (fast_a ? !s2 : s2);
  assign b1_h = !slow_b && (fast_b ? !s3 : s3);
  assign b2_h = !slow_b && (fast_b ? !s4 : s4);

  // Slow decay shorts the coil through both low sides
  assign a1_l = slow_a || (fast_a ? s1 : !s1);
  assign a2_l = slow_a || (fast_a ? s2 : !s2);
  assign b1_l = slow_b || (fast_b ? s3 : !s3);
  assign b2_l = slow_b || (fast_b ? s4 : !s4);

  // Disabled or faulted: high sides off, low sides on
  assign drive_ok = enable && faultn;

  assign phase_a1_h_out = config_invert_highside ^ (a1_h && drive_ok);
  assign phase_a2_h_out = config_invert_highside ^ (a2_h && drive_ok);
  assign phase_b1_h_out = config_invert_highside ^ (b1_h && drive_ok);
  assign phase_b2_h_out = config_invert_highside ^ (b2_h && drive_ok);

  assign phase_a1_l_out = config_invert_lowside ^ (a1_l || !drive_ok);
  assign phase_a2_l_out = config_invert_lowside ^ (a2_l || !drive_ok);
  assign phase_b1_l_out = config_invert_lowside ^ (b1_l || !drive_ok);
  assign phase_b2_l_out = config_invert_lowside ^ (b2_l || !drive_ok);

  // Off time request once blanking is over and no off time is running
  assign coil_a.offtimer_en = analog_cmp1 && (coil_a.blank_timer == '0) &&
                              (coil_a.off_timer == '0);
  assign coil_b.offtimer_en = analog_cmp2 && (coil_b.blank_timer == '0) &&
                              (coil_b.off_timer == '0);

endmodule

//--- hdl/microstepper_top.sv
module microstepper_top (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     step,
  input  logic                     dir,
  input  logic                     enable_in,
  input  logic                     config_invert_highside,
  input  logic                     config_invert_lowside,
  input  stepper_pkg::long_time_t  config_fastdecay_threshold,
  input  stepper_pkg::long_time_t  config_off_time,
  input  stepper_pkg::short_time_t config_blank_time,
  input  stepper_pkg::short_time_t config_min_on_time,
  input  logic                     analog_cmp1,
  input  logic                     analog_cmp2,
  output stepper_pkg::phase_t      phase_ct,
  output logic                     faultn,
  output stepper_pkg::vref_t       vref_a,
  output stepper_pkg::vref_t       vref_b,
  output logic                     phase_a1_h_out,
  output logic                     phase_a2_h_out,
  output logic                     phase_b1_h_out,
  output logic                     phase_b2_h_out,
  output logic                     phase_a1_l_out,
  output logic                     phase_a2_l_out,
  output logic                     phase_b1_l_out,
  output logic                     phase_b2_l_out
);

  logic enable;
  logic s1, s2, s3, s4;

  coil_timer_if coil_a_if ();
  coil_timer_if coil_b_if ();

  microstepper_control control_i (
    .clk                        (clk),
    .resetn                     (resetn),
    .step                       (step),
    .dir                        (dir),
    .enable_in                  (enable_in),
    .config_invert_highside     (config_invert_highside),
    .config_invert_lowside      (config_invert_lowside),
    .config_fastdecay_threshold (config_fastdecay_threshold),
    .s1                         (s1),
    .s2                         (s2),
    .s3                         (s3),
    .s4                         (s4),
    .coil_a                     (coil_a_if.control),
    .coil_b                     (coil_b_if.control),
    .analog_cmp1                (analog_cmp1),
    .analog_cmp2                (analog_cmp2),
    .phase_ct                   (phase_ct),
    .enable                     (enable),
    .faultn                     (faultn),
    .phase_a1_h_out             (phase_a1_h_out),
    .phase_a2_h_out             (phase_a2_h_out),
    .phase_b1_h_out             (phase_b1_h_out),
    .phase_b2_h_out             (phase_b2_h_out),
    .phase_a1_l_out             (phase_a1_l_out),
    .phase_a2_l_out             (phase_a2_l_out),
    .phase_b1_l_out             (phase_b1_l_out),
    .phase_b2_l_out             (phase_b2_l_out)
  );

  phase_decoder decoder_i (
    .clk      (clk),
    .resetn   (resetn),
    .phase_ct (phase_ct),
    .s1       (s1),
    .s2       (s2),
    .s3       (s3),
    .s4       (s4),
    .vref_a   (vref_a),
    .vref_b   (vref_b)
  );

  // One chopper per coil, same timing configuration
  chopper_timers chop_a (
    .clk                (clk),
    .resetn             (resetn),
    .enable             (enable),
    .config_off_time    (config_off_time),
    .config_blank_time  (config_blank_time),
    .config_min_on_time (config_min_on_time),
    .timers             (coil_a_if.timer)
  );

  chopper_timers chop_b (
    .clk                (clk),
    .resetn             (resetn),
    .enable             (enable),
    .config_off_time    (config_off_time),
    .config_blank_time  (config_blank_time),
    .config_min_on_time (config_min_on_time),
    .timers             (coil_b_if.timer)
  );

endmodule

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Expected phase after one step
function automatic logic [7:0] next_phase(input logic [7:0] p, input logic d);
  return d ? p + 8'd1 : p - 8'd1;
endfunction

// Coil reference, 255 * |cos| for coil A or 255 * |sin| for coil B
function automatic int ref_vref(input logic [7:0] p, input bit use_sin);
  real ang;
  real v;
  ang = 2.0 * 3.14159265358979 * p / 256.0;
  v = use_sin ? $sin(ang) : $cos(ang);
  if (v < 0.0) v = -v;
  return $rtoi(v * 255.0 + 0.5);
endfunction

// Sign of cos or sin, zero crossings count as positive
function automatic bit ref_pos(input logic [7:0] p, input bit use_sin);
  real ang;
  ang = 2.0 * 3.14159265358979 * p / 256.0;
  return (use_sin ? $sin(ang) : $cos(ang)) >= -1.0e-9;
endfunction

function automatic bit is_active(input logic out, input logic inv);
  return out ^ inv;
endfunction

task automatic mismatch(input string what);
  stop_run($sformatf("mismatch at %0t: %s", $time, what));
endtask

assert property (@(posedge clk) disable iff (!resetn)
  vref_a == ref_vref(phase_d, 0) && vref_b == ref_vref(phase_d, 1))
  else mismatch("coil reference does not follow phase");

assert property (@(posedge clk) disable iff (!resetn) decode_check |->
  is_active(phase_a1_h_out, config_invert_highside) == ref_pos(phase_d, 0) &&
  is_active(phase_a2_h_out, config_invert_highside) == !ref_pos(phase_d, 0) &&
  is_active(phase_b1_h_out, config_invert_highside) == ref_pos(phase_d, 1) &&
  is_active(phase_b2_h_out, config_invert_highside) == !ref_pos(phase_d, 1))
  else mismatch("bridge polarity does not follow phase");

// High and low side of a half bridge never both on
assert property (@(posedge clk) disable iff (!resetn)
  !(is_active(phase_a1_h_out, config_invert_highside) &&
    is_active(phase_a1_l_out, config_invert_lowside)) &&
  !(is_active(phase_a2_h_out, config_invert_highside) &&
    is_active(phase_a2_l_out, config_invert_lowside)) &&
  !(is_active(phase_b1_h_out, config_invert_highside) &&
    is_active(phase_b1_l_out, config_invert_lowside)) &&
  !(is_active(phase_b2_h_out, config_invert_highside) &&
    is_active(phase_b2_l_out, config_invert_lowside)))
  else mismatch("shoot-through on a half bridge");

assert property (@(posedge clk) disable iff (!resetn) disabled_ct >= 2 |->
  !high_any && low_all)
  else mismatch("outputs not in safe state while disabled");

assert property (@(posedge clk) disable iff (!resetn) fault_seen |->
  !faultn && !high_any)
  else mismatch("fault not held or high side on during fault");

// Fast decay swaps the diagonal, slow decay turns both low sides on
assert property (@(posedge clk) disable iff (!resetn)
  chop_check && model_off_a != 0 && model_off_a >= config_fastdecay_threshold |->
  is_active(phase_a1_h_out, config_invert_highside) == !ref_pos(phase_d, 0) &&
  is_active(phase_a2_h_out, config_invert_highside) == ref_pos(phase_d, 0))
  else mismatch("coil A fast decay drive");

assert property (@(posedge clk) disable iff (!resetn)
  chop_check && model_off_b != 0 && model_off_b >= config_fastdecay_threshold |->
  is_active(phase_b1_h_out, config_invert_highside) == !ref_pos(phase_d, 1) &&
  is_active(phase_b2_h_out, config_invert_highside) == ref_pos(phase_d, 1))
  else mismatch("coil B fast decay drive");

assert property (@(posedge clk) disable iff (!resetn)
  chop_check && model_off_a != 0 && model_off_a < config_fastdecay_threshold |->
  is_active(phase_a1_l_out, config_invert_lowside) &&
  is_active(phase_a2_l_out, config_invert_lowside))
  else mismatch("coil A slow decay drive");

assert property (@(posedge clk) disable iff (!resetn)
  chop_check && model_off_b != 0 && model_off_b < config_fastdecay_threshold |->
  is_active(phase_b1_l_out, config_invert_lowside) &&
  is_active(phase_b2_l_out, config_invert_lowside))
  else mismatch("coil B slow decay drive");

`endif

//--- test/microstepper_tb.sv
module microstepper_tb;

  localparam int RESET_CYCLES = 16;
  localparam int STEPS        = 200;
  localparam int CHOP_CYCLES  = 400;
  localparam int PLAN_CYCLES  = RESET_CYCLES + 8 + STEPS * 6 + 4 * 12 + CHOP_CYCLES + 80;
  localparam int CYCLE_LIMIT  = 2 * PLAN_CYCLES;

  logic       clk;
  logic       resetn;
  logic       step;
  logic       dir;
  logic       enable_in;
  logic       config_invert_highside;
  logic       config_invert_lowside;
  logic [9:0] config_fastdecay_threshold;
  logic [9:0] config_off_time;
  logic [7:0] config_blank_time;
  logic [7:0] config_min_on_time;
  logic       analog_cmp1;
  logic       analog_cmp2;
  logic [7:0] phase_ct;
  logic       faultn;
  logic [7:0] vref_a;
  logic [7:0] vref_b;
  logic       phase_a1_h_out, phase_a2_h_out, phase_b1_h_out, phase_b2_h_out;
  logic       phase_a1_l_out, phase_a2_l_out, phase_b1_l_out, phase_b2_l_out;

  logic [7:0] model_phase;
  logic [7:0] phase_d;
  logic [9:0] model_off_a;
  logic [9:0] model_off_b;
  logic [1:0] disabled_ct;
  logic       fault_seen;
  logic       decode_check;
  logic       chop_check;
  logic       high_any;
  logic       low_all;
  int         cycle_ct;

  microstepper_top dut_i (.*);

  assign high_any = (phase_a1_h_out ^ config_invert_highside) |
                    (phase_a2_h_out ^ config_invert_highside) |
                    (phase_b1_h_out ^ config_invert_highside) |
                    (phase_b2_h_out ^ config_invert_highside);
  assign low_all = (phase_a1_l_out ^ config_invert_lowside) &
                   (phase_a2_l_out ^ config_invert_lowside) &
                   (phase_b1_l_out ^ config_invert_lowside) &
                   (phase_b2_l_out ^ config_invert_lowside);

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1);
  endtask

  `include "tb_checks.svh"

  initial begin
    clk = 1'b0;
    forever #50 clk = !clk;
  end

  always @(posedge clk) begin
    cycle_ct <= cycle_ct + 1;
    if (cycle_ct >= CYCLE_LIMIT) begin
      stop_run("timeout: the run did not finish within the cycle limit");
    end
  end

  // Off timer model loaded from the observed request
  always @(posedge clk) begin
    phase_d <= phase_ct;
    if (!resetn) begin
      model_off_a <= '0;
      model_off_b <= '0;
      fault_seen  <= 1'b0;
      disabled_ct <= '0;
    end else begin
      if (dut_i.coil_a_if.offtimer_en) model_off_a <= config_off_time;
      else model_off_a <= (model_off_a <= 10'd1) ? 10'd0 : model_off_a - 10'd1;
      if (dut_i.coil_b_if.offtimer_en) model_off_b <= config_off_time;
      else model_off_b <= (model_off_b <= 10'd1) ? 10'd0 : model_off_b - 10'd1;
      if (!faultn) fault_seen <= 1'b1;
      if (enable_in) disabled_ct <= '0;
      else if (disabled_ct != 2'd3) disabled_ct <= disabled_ct + 2'd1;
    end
  end

  // One pulse of 3 cycles high and 3 low with the phase checked around the count stage
  task automatic step_once(input logic d);
    logic [7:0] prev_phase;
    prev_phase = model_phase;
    dir  = d;
    step = 1'b1;
    model_phase = next_phase(model_phase, d);
    repeat (3) @(negedge clk);
    assert (phase_ct == prev_phase)
      else mismatch("phase count changed before the count stage");
    step = 1'b0;
    @(negedge clk);
    assert (phase_ct == model_phase) else mismatch("phase count after step");
    repeat (2) @(negedge clk);
  endtask

  initial begin
    void'($urandom(32'h4876bfff));
    cycle_ct = 0;
    resetn = 1'b0;
    step = 1'b0;
    dir = 1'b0;
    enable_in = 1'b0;
    config_invert_highside = 1'b0;
    config_invert_lowside = 1'b0;
    config_fastdecay_threshold = 10'd30;
    config_off_time = 10'd60;
    config_blank_time = 8'd20;
    config_min_on_time = 8'd10;
    analog_cmp1 = 1'b0;
    analog_cmp2 = 1'b0;
    model_phase = 8'd0;
    decode_check = 1'b0;
    chop_check = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
    assert (phase_ct == 8'd0 && faultn) else mismatch("state after reset");

    enable_in = 1'b1;
    repeat (8) @(negedge clk);
    decode_check = 1'b1;
    // Mostly upward so the walk crosses the quadrant boundaries
    for (int i = 0; i < STEPS; i++) begin
      step_once(($urandom % 8) != 0);
    end
    decode_check = 1'b0;

    for (int i = 0; i < 4; i++) begin
      {config_invert_highside, config_invert_lowside} = i[1:0];
      enable_in = 1'b0;
      repeat (6) @(negedge clk);
      enable_in = 1'b1;
      repeat (6) @(negedge clk);
    end
    config_invert_highside = 1'b0;
    config_invert_lowside = 1'b0;

    // Random comparator pulses with min-on shorter than blanking
    chop_check = 1'b1;
    repeat (CHOP_CYCLES) begin
      @(negedge clk);
      analog_cmp1 = ($urandom % 6) == 0;
      analog_cmp2 = ($urandom % 6) == 0;
    end
    analog_cmp1 = 1'b0;
    analog_cmp2 = 1'b0;
    chop_check = 1'b0;

    // Min-on longer than blanking and reloaded through a disable cycle
    enable_in = 1'b0;
    repeat (3) @(negedge clk);
    config_min_on_time = 8'd40;
    enable_in = 1'b1;
    repeat (24) @(negedge clk);
    analog_cmp1 = 1'b1;
    while (faultn) @(negedge clk);
    repeat (20) @(negedge clk);
    analog_cmp1 = 1'b0;
    resetn = 1'b0;
    repeat (4) @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
    assert (faultn) else mismatch("fault still set after reset");

    $display("No errors");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
hdl/stepper_pkg.sv
hdl/coil_timer_if.sv
hdl/phase_decoder.sv
hdl/chopper_timers.sv
hdl/microstepper_control.sv
hdl/microstepper_top.sv
test/microstepper_tb.sv
